/* Makefile */
# Verilator build and run for the microsequencer

VERILATOR  ?= verilator
TOP        ?= micro_sequencer_tb
RTL_TOP    ?= micro_sequencer_top
FILELIST   ?= micro_sequencer.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps
PASS_MSG   ?= ALL TESTS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass or fail comes from the simulation output
run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* micro_sequencer.f */
source/micro_word_pkg.sv
source/cpu_status_pkg.sv
source/micro_counter.sv
source/dispatch_decoder.sv
source/branch_condition.sv
source/control_section.sv
source/control_store.sv
source/micro_sequencer_top.sv
testbench/micro_sequencer_tb.sv

/* source/branch_condition.sv */
// Branch condition select
// Picks one status input by the branch field, inverts it and
// applies the polarity bit to form the active-low counter load

`timescale 1ns/100ps

module branch_condition (
    input  micro_word_pkg::bop_t    bop,
    input  cpu_status_pkg::status_t status,
    input  logic                    go_bar,
    output logic                    mpc_load_bar
);

    logic [2:0] cond_sel;
    logic       polarity;
    logic       cond_value;

    assign polarity = bop[3];
    assign cond_sel = bop[2:0];

    // Eight-way select, unused inputs tied low
    always_comb begin
        case (cond_sel)
            3'd0: begin
                cond_value = status.negative;
            end
            3'd2: begin
                cond_value = status.zero;
            end
            3'd3: begin
                cond_value = status.carry;
            end
            3'd4: begin
                cond_value = go_bar;
            end
            3'd5: begin
                cond_value = status.overflow;
            end
            default: begin
                cond_value = 1'b0;
            end
        endcase
    end

    // Polarity 0 loads on a high input, polarity 1 on a low one
    assign mpc_load_bar = (~cond_value) ^ polarity;

endmodule

/* source/control_section.sv */
// Control section of the 8-bit processor
// Splits the microword, drives the microprogram counter and
// overrides the outgoing address with the jam vector

`timescale 1ns/100ps

module control_section (
    input  logic                                  system_clk,
    input  logic                                  rst_n,
    input  cpu_status_pkg::opcode_t               opcode,
    input  logic                                  go_bar,
    input  logic                                  jam,
    input  cpu_status_pkg::status_t               status,
    input  micro_word_pkg::micro_word_t           mw,
    output micro_word_pkg::micro_addr_t           micro_address,
    output logic [micro_word_pkg::CONTROL_W-1:0]  control_bits,
    output logic                                  eil_bar
);

    import micro_word_pkg::*;

    // Microword fields
    bop_t        bop;
    logic        count;
    logic [3:0]  addr_high;
    logic [3:0]  addr_low;

    logic [3:0]  target_high;
    micro_addr_t load_target;
    micro_addr_t count_value;
    logic        mpc_load_bar;

    assign control_bits = mw.control;
    assign bop          = mw.bop;
    assign count        = mw.count;
    assign addr_high    = mw.addr_high;
    assign addr_low     = mw.addr_low;

    assign load_target = {target_high, addr_low};

    micro_counter u_micro_counter (
        .system_clk   (system_clk),
        .rst_n        (rst_n),
        .target       (load_target),
        .mpc_load_bar (mpc_load_bar),
        .count        (count),
        .count_value  (count_value)
    );

    dispatch_decoder u_dispatch_decoder (
        .opcode      (opcode),
        .bop         (bop),
        .addr_high   (addr_high),
        .target_high (target_high),
        .eil_bar     (eil_bar)
    );

    branch_condition u_branch_condition (
        .bop          (bop),
        .status       (status),
        .go_bar       (go_bar),
        .mpc_load_bar (mpc_load_bar)
    );

    // Jam acts on the bus only, the counter keeps running
    assign micro_address = jam ? JAM_ADDR : count_value;

endmodule

/* source/control_store.sv */
// Control store
// Fixed demonstration microprogram, read combinationally by address
// Routine for opcode op lives at {op, 0} through {op, 2}

`timescale 1ns/100ps

module control_store (
    input  micro_word_pkg::micro_addr_t micro_address,
    output micro_word_pkg::micro_word_t mw
);

    import micro_word_pkg::*;

    logic [3:0] op;
    logic [3:0] step;

    assign op   = micro_address[7:4];
    assign step = micro_address[3:0];

    always_comb begin
        // Unused words jump back to idle
        mw.control   = '0;
        mw.bop       = BOP_JUMP;
        mw.count     = 1'b0;
        mw.addr_high = 4'h0;
        mw.addr_low  = 4'h0;

        if (micro_address == JAM_ADDR) begin
            mw.control = 11'h7FF;
        end else if (op == 4'h0) begin
            case (step)
                4'h0: begin
                    // Idle until go_bar drops
                    mw.bop   = BOP_WAIT_GO;
                    mw.count = 1'b1;
                end
                4'h1: begin
                    mw.control = 11'h001;
                    mw.bop     = BOP_NONE;
                    mw.count   = 1'b1;
                end
                4'h2: begin
                    // Opcode selects the routine
                    mw.control = 11'h002;
                    mw.bop     = BOP_DISPATCH;
                end
                default: begin
                end
            endcase
        end else begin
            case (step)
                4'h0: begin
                    mw.control = 11'h400 + {7'b0, op};
                    mw.bop     = BOP_NONE;
                    mw.count   = 1'b1;
                end
                4'h1: begin
                    // Early return to fetch on a zero result
                    mw.control                  = 11'h200;
                    mw.bop                      = BOP_IF_ZERO;
                    mw.count                    = 1'b1;
                    {mw.addr_high, mw.addr_low} = FETCH_ADDR;
                end
                4'h2: begin
                    mw.control                  = 11'h100;
                    mw.bop                      = BOP_JUMP;
                    {mw.addr_high, mw.addr_low} = FETCH_ADDR;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* source/cpu_status_pkg.sv */
// Processor datapath types seen by the control section
// Opcode width and status flag layout

package cpu_status_pkg;

    localparam int OPCODE_W = 4;

    typedef logic [OPCODE_W-1:0] opcode_t;

    // Flags from the ALU, overflow in the top bit
    typedef struct packed {
        logic overflow;
        logic negative;
        logic carry;
        logic zero;
    } status_t;

endpackage

/* source/dispatch_decoder.sv */
// Opcode dispatch decoder
// Substitutes the opcode for the target high nibble on a dispatch
// and enables the instruction latch in the same cycle

`timescale 1ns/100ps

module dispatch_decoder (
    input  cpu_status_pkg::opcode_t opcode,
    input  micro_word_pkg::bop_t    bop,
    input  logic [3:0]              addr_high,
    output logic [3:0]              target_high,
    output logic                    eil_bar
);

    import micro_word_pkg::*;

    logic dispatch;

    assign dispatch = (bop == BOP_DISPATCH);

    // Opcode picks the routine, the microword keeps the low nibble
    assign target_high = dispatch ? opcode : addr_high;

    // Instruction latch enable, active low
    assign eil_bar = ~dispatch;

endmodule

/* source/micro_counter.sv */
// Microprogram counter
// Loads a branch target, increments or holds once per clock

`timescale 1ns/100ps

module micro_counter (
    input  logic                       system_clk,
    input  logic                       rst_n,
    input  micro_word_pkg::micro_addr_t target,
    input  logic                       mpc_load_bar,
    input  logic                       count,
    output micro_word_pkg::micro_addr_t count_value
);

    // Load wins over increment
    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            count_value <= '0;
        end else if (!mpc_load_bar) begin
            count_value <= target;
        end else if (count) begin
            count_value <= count_value + 8'd1;
        end
    end

    // Counter starts from word 0 once reset has been seen
    reset_clears_counter: assert property (
        @(posedge system_clk) !rst_n |=> (count_value == '0)
    ) else $error("micro_counter: value not cleared after reset");

endmodule

/* source/micro_sequencer_top.sv */
// Microsequencer top level
// Closes the loop between the control section and its control store

`timescale 1ns/100ps

module micro_sequencer_top (
    input  logic                                  system_clk,
    input  logic                                  rst_n,
    input  cpu_status_pkg::opcode_t               opcode,
    input  logic                                  go_bar,
    input  logic                                  jam,
    input  cpu_status_pkg::status_t               status,
    output micro_word_pkg::micro_addr_t           micro_address,
    output logic [micro_word_pkg::CONTROL_W-1:0]  control_bits,
    output logic                                  eil_bar
);

    import micro_word_pkg::*;

    // Current microword from the store
    micro_word_t mw;

    control_section u_control_section (
        .system_clk    (system_clk),
        .rst_n         (rst_n),
        .opcode        (opcode),
        .go_bar        (go_bar),
        .jam           (jam),
        .status        (status),
        .mw            (mw),
        .micro_address (micro_address),
        .control_bits  (control_bits),
        .eil_bar       (eil_bar)
    );

    control_store u_control_store (
        .micro_address (micro_address),
        .mw            (mw)
    );

endmodule

/* source/micro_word_pkg.sv */
// Microword format for the microprogrammed control section
// Field layout, branch operation codes and fixed microaddresses

package micro_word_pkg;

    // Width of the control field passed to the datapath
    localparam int CONTROL_W = 11;

    typedef logic [7:0] micro_addr_t;

    // Bit 3 is the polarity, bits 2:0 select the condition
    typedef enum logic [3:0] {
        BOP_NONE     = 4'b0001,
        BOP_IF_ZERO  = 4'b0010,
        BOP_IF_CARRY = 4'b0011,
        BOP_WAIT_GO  = 4'b0100,
        BOP_JUMP     = 4'b1001,
        BOP_DISPATCH = 4'b1110
    } bop_t;

    // 24-bit microword, most significant field first
    typedef struct packed {
        logic [CONTROL_W-1:0] control;
        bop_t                 bop;
        logic                 count;
        logic [3:0]           addr_high;
        logic [3:0]           addr_low;
    } micro_word_t;

    // Address forced onto the bus while jam is high
    localparam micro_addr_t JAM_ADDR = 8'hFF;

    // Start of the instruction fetch sequence
    localparam micro_addr_t FETCH_ADDR = 8'h01;

endpackage

/* testbench/micro_sequencer_tb.sv */
// Testbench for the microsequencer top level
// Replays per-cycle stimulus from the test data file and checks the
// outgoing microaddress, control bits and instruction latch enable

`timescale 1ns/100ps

module micro_sequencer_tb;

    import micro_word_pkg::*;
    import cpu_status_pkg::*;

    localparam int    CLK_PERIOD     = 8;
    localparam int    RESET_CYCLES   = 5;
    localparam int    TIMEOUT_MARGIN = 20;
    localparam string DATA_FILE      = "testbench/micro_sequencer_testdata.txt";

    // One clock cycle of stimulus and the outputs expected in that cycle
    typedef struct packed {
        opcode_t               opcode;
        logic                  go_bar;
        logic                  jam;
        status_t               status;
        micro_addr_t           exp_addr;
        logic [CONTROL_W-1:0]  exp_ctrl;
        logic                  exp_eil;
    } vector_t;

    logic                  system_clk = 1'b0;
    logic                  rst_n;
    opcode_t               opcode;
    logic                  go_bar;
    logic                  jam;
    status_t               status;
    micro_addr_t           micro_address;
    logic [CONTROL_W-1:0]  control_bits;
    logic                  eil_bar;

    vector_t vectors[$];
    int      addr_errors  = 0;
    int      ctrl_errors  = 0;
    int      eil_errors   = 0;
    int      other_errors = 0;
    int      cycle_count  = 0;
    int      cycle_limit  = RESET_CYCLES + TIMEOUT_MARGIN;

    micro_sequencer_top UUT (
        .system_clk    (system_clk),
        .rst_n         (rst_n),
        .opcode        (opcode),
        .go_bar        (go_bar),
        .jam           (jam),
        .status        (status),
        .micro_address (micro_address),
        .control_bits  (control_bits),
        .eil_bar       (eil_bar)
    );

    always #(CLK_PERIOD / 2) system_clk = ~system_clk;

    // Reads every vector line, skipping comments and blank lines
    task automatic load_vectors();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        vector_t     v;
        int unsigned f_op, f_go, f_jam, f_st, f_addr, f_ctrl, f_eil;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test data file %s", DATA_FILE);
            other_errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_op, f_go, f_jam, f_st, f_addr, f_ctrl, f_eil);
            if (n != 7) begin
                $display("Line %0d of the test data file could not be read", line_no);
                other_errors++;
                continue;
            end
            v.opcode   = f_op[3:0];
            v.go_bar   = f_go[0];
            v.jam      = f_jam[0];
            v.status   = f_st[3:0];
            v.exp_addr = f_addr[7:0];
            v.exp_ctrl = f_ctrl[CONTROL_W-1:0];
            v.exp_eil  = f_eil[0];
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic check_outputs(input vector_t v);
        assert (micro_address === v.exp_addr) else begin
            $display("Mismatch at %0d ns: micro_address expected %h, got %h",
                     $time, v.exp_addr, micro_address);
            addr_errors++;
        end
        assert (control_bits === v.exp_ctrl) else begin
            $display("Mismatch at %0d ns: control_bits expected %h, got %h",
                     $time, v.exp_ctrl, control_bits);
            ctrl_errors++;
        end
        assert (eil_bar === v.exp_eil) else begin
            $display("Mismatch at %0d ns: eil_bar expected %b, got %b",
                     $time, v.exp_eil, eil_bar);
            eil_errors++;
        end
    endtask

    task automatic report_counts();
        $display("Errors: micro_address %0d, control_bits %0d, eil_bar %0d, other %0d",
                 addr_errors, ctrl_errors, eil_errors, other_errors);
    endtask

    // Watchdog with a limit that follows the number of vectors
    always @(posedge system_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the vectors did not finish", cycle_count);
            report_counts();
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        rst_n  = 1'b0;
        opcode = '0;
        go_bar = 1'b1;
        jam    = 1'b0;
        status = '0;

        load_vectors();
        cycle_limit = vectors.size() + RESET_CYCLES + TIMEOUT_MARGIN;
        if (vectors.size() == 0) begin
            $display("No test vectors were loaded");
            other_errors++;
        end

        repeat (RESET_CYCLES) @(posedge system_clk);
        rst_n <= 1'b1;

        // Drive on the edge, check one ns before the next edge
        foreach (vectors[i]) begin
            opcode <= vectors[i].opcode;
            go_bar <= vectors[i].go_bar;
            jam    <= vectors[i].jam;
            status <= vectors[i].status;
            #(CLK_PERIOD - 1);
            check_outputs(vectors[i]);
            @(posedge system_clk);
        end

        total = addr_errors + ctrl_errors + eil_errors + other_errors;
        report_counts();
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/micro_sequencer_testdata.txt */
# opcode go_bar jam status | expected micro_address control_bits eil_bar, all hex
# One line per clock cycle after reset; status bits are overflow negative carry zero
0 1 0 0 00 000 1
0 1 0 0 00 000 1
0 0 0 0 00 000 1
3 1 0 0 01 001 1
3 1 0 0 02 002 0
3 1 0 0 30 403 1
3 1 0 1 31 200 1
5 1 0 0 01 001 1
5 1 0 0 02 002 0
5 1 0 0 50 405 1
5 1 0 0 51 200 1
5 1 0 0 52 100 1
0 1 0 0 01 001 1
0 1 0 0 02 002 0
0 1 0 0 00 000 1
0 1 0 0 00 000 1
0 0 0 0 00 000 1
a 1 0 0 01 001 1
a 1 0 0 02 002 0
a 1 0 0 a0 40a 1
a 1 1 0 ff 7ff 1
a 1 1 0 ff 7ff 1
a 1 0 0 00 000 1
a 1 0 0 00 000 1
a 0 0 0 00 000 1
f 1 0 0 01 001 1
f 1 0 0 02 002 0
f 1 0 0 f0 40f 1
f 1 0 e f1 200 1
f 1 0 0 f2 100 1
1 1 0 0 01 001 1
1 1 0 0 02 002 0
1 1 0 0 10 401 1
1 1 0 f 11 200 1
1 1 0 0 01 001 1
